// ==== hdl/booth_mul_top.sv ====
// 64x64 booth/wallace multiplier, per-operand signedness, 4-cycle latency, one op per cycle
`timescale 1ns/10ps

module booth_mul_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid_i,
  input  logic              a_signed_i,
  input  logic              b_signed_i,
  input  mul_pkg::operand_t a_i,
  input  mul_pkg::operand_t b_i,
  output logic              in_ready_o,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output mul_pkg::row_t     product_o
);
  import mul_pkg::*;

  logic advance;
  row_t pp [PP_ROWS];
  row_t tree_sum;
  row_t tree_carry;

  mul_pipe_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .in_valid_i (in_valid_i),
    .out_ready_i(out_ready_i),
    .in_ready_o (in_ready_o),
    .out_valid_o(out_valid_o),
    .advance_o  (advance)
  );

  // partial products straight from the input ports
  booth_r4_encoder u_booth (
    .a_i       (a_i),
    .b_i       (b_i),
    .a_signed_i(a_signed_i),
    .b_signed_i(b_signed_i),
    .pp_o      (pp)
  );

  wallace_tree u_tree (
    .clk      (clk),
    .advance_i(advance),
    .pp_i     (pp),
    .sum_o    (tree_sum),
    .carry_o  (tree_carry)
  );

  final_adder u_add (
    .clk      (clk),
    .advance_i(advance),
    .sum_i    (tree_sum),
    .carry_i  (tree_carry),
    .product_o(product_o)
  );

endmodule

// ==== hdl/booth_r4_encoder.sv ====
// radix-4 booth partial products, purely combinational; row layout assumes 64-bit operands
`timescale 1ns/10ps

module booth_r4_encoder (
  input  mul_pkg::operand_t a_i,
  input  mul_pkg::operand_t b_i,
  input  logic              a_signed_i,
  input  logic              b_signed_i,
  output mul_pkg::row_t     pp_o [mul_pkg::PP_ROWS]
);
  import mul_pkg::*;

  localparam int EXT_W = DATA_W + 2;

  logic [EXT_W-1:0] a_ext;
  logic [EXT_W-1:0] b_ext;
  // multiplier with the implicit zero below bit 0
  logic [EXT_W:0]   b_pad;
  row_t             a_wide;

  // select 0, +-A or +-2A from one three-bit group
  function automatic row_t booth_multiple(input logic [2:0] grp, input row_t a_full);
    row_t m;
    case (grp)
      3'b001, 3'b010: begin
        m = a_full;
      end
      3'b011: begin
        m = a_full << 1;
      end
      3'b100: begin
        m = -(a_full << 1);
      end
      3'b101, 3'b110: begin
        m = -a_full;
      end
      default: begin
        m = '0;
      end
    endcase
    return m;
  endfunction

  // sign or zero extension by two bits
  assign a_ext = {{2{a_signed_i & a_i[DATA_W-1]}}, a_i};
  assign b_ext = {{2{b_signed_i & b_i[DATA_W-1]}}, b_i};
  assign b_pad = {b_ext, 1'b0};

  // A spread over the full product width
  assign a_wide = {{(PROD_W - EXT_W){a_ext[EXT_W-1]}}, a_ext};

  // group i covers b_pad bits 2i+2 down to 2i
  for (genvar i = 0; i < PP_ROWS; i++) begin : g_row
    assign pp_o[i] = booth_multiple(b_pad[2*i+2 -: 3], a_wide) << (2 * i);
  end

endmodule

// ==== hdl/csa_level.sv ====
// one wallace level of 3:2 compressors, combinational; carry top bit is dropped at 128 bits
`timescale 1ns/10ps

module csa_level #(
  parameter int IN_ROWS = 3
) (
  input  mul_pkg::row_t rows_i [IN_ROWS],
  output mul_pkg::row_t rows_o [mul_pkg::rows_after(IN_ROWS)]
);
  import mul_pkg::*;

  localparam int GROUPS = IN_ROWS / 3;
  localparam int LEFT = IN_ROWS % 3;

  for (genvar g = 0; g < GROUPS; g++) begin : g_csa
    row_t sum;
    row_t carry;

    // bitwise full adders
    assign sum = rows_i[3*g] ^ rows_i[3*g+1] ^ rows_i[3*g+2];
    assign carry = (rows_i[3*g] & rows_i[3*g+1]) |
                   (rows_i[3*g] & rows_i[3*g+2]) |
                   (rows_i[3*g+1] & rows_i[3*g+2]);

    assign rows_o[2*g] = sum;
    // carry weighs one bit more
    assign rows_o[2*g+1] = {carry[PROD_W-2:0], 1'b0};
  end

  // leftover rows go to the end of the list
  for (genvar k = 0; k < LEFT; k++) begin : g_pass
    assign rows_o[2*GROUPS+k] = rows_i[3*GROUPS+k];
  end

endmodule

// ==== hdl/final_adder.sv ====
// 128-bit carry-propagate add of the tree output, one register stage held during stalls
`timescale 1ns/10ps

module final_adder (
  input  logic          clk,
  input  logic          advance_i,
  input  mul_pkg::row_t sum_i,
  input  mul_pkg::row_t carry_i,
  output mul_pkg::row_t product_o
);

  // product register, frozen while the output waits
  always_ff @(posedge clk) begin
    if (advance_i) begin
      product_o <= sum_i + carry_i;
    end
  end

endmodule

// ==== hdl/mul_pipe_ctrl.sv ====
// valid/ready control for the multiplier pipe; no bubble squeezing, whole pipe stalls on backpressure
`timescale 1ns/10ps

module mul_pipe_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic in_valid_i,
  input  logic out_ready_i,
  output logic in_ready_o,
  output logic out_valid_o,
  output logic advance_o
);
  import mul_pkg::*;

  // one valid bit per register stage
  logic [PIPE_DEPTH-1:0] stage_valid;

  // stall only when a finished product is not taken
  assign advance_o = ~(stage_valid[PIPE_DEPTH-1] & ~out_ready_i);

  // the first stage loads whenever the pipe moves
  assign in_ready_o = advance_o;

  assign out_valid_o = stage_valid[PIPE_DEPTH-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= '0;
    end else if (advance_o) begin
      stage_valid <= {stage_valid[PIPE_DEPTH-2:0], in_valid_i};
    end
  end

endmodule

// ==== hdl/mul_pkg.sv ====
// shared widths and row counts for the 64x64 booth multiplier; 33 booth rows assume DATA_W = 64
package mul_pkg;

  // operand and product widths
  localparam int DATA_W = 64;
  localparam int PROD_W = 2 * DATA_W;

  // two extension bits give 33 radix-4 digit groups
  localparam int PP_ROWS = (DATA_W + 2) / 2;

  // wallace tree shape
  localparam int TREE_LEVELS = 8;
  localparam int CUT_LEVEL = 4;

  // register stages from acceptance to product
  localparam int PIPE_DEPTH = 4;

  typedef logic [DATA_W-1:0] operand_t;
  typedef logic [PROD_W-1:0] row_t;

  // rows left after one 3:2 level
  // full groups of three become two, leftovers pass through
  function automatic int rows_after(input int rows);
    return (rows / 3) * 2 + (rows % 3);
  endfunction

  // rows left after a number of levels starting from the booth rows
  function automatic int rows_at_level(input int level);
    int rows;
    rows = PP_ROWS;
    for (int i = 0; i < level; i++) begin
      rows = rows_after(rows);
    end
    return rows;
  endfunction

endpackage

// ==== hdl/wallace_tree.sv ====
// eight-level wallace tree with registers on pp input, after level 4 and after level 8
`timescale 1ns/10ps

module wallace_tree (
  input  logic          clk,
  input  logic          advance_i,
  input  mul_pkg::row_t pp_i [mul_pkg::PP_ROWS],
  output mul_pkg::row_t sum_o,
  output mul_pkg::row_t carry_o
);
  import mul_pkg::*;

  // row counts along the tree
  localparam int R1 = rows_after(PP_ROWS);
  localparam int R2 = rows_after(R1);
  localparam int R3 = rows_after(R2);
  localparam int CUT_ROWS = rows_at_level(CUT_LEVEL);
  localparam int R5 = rows_after(CUT_ROWS);
  localparam int R6 = rows_after(R5);
  localparam int R7 = rows_after(R6);
  localparam int END_ROWS = rows_at_level(TREE_LEVELS);

  row_t pp_q  [PP_ROWS];
  row_t lv1   [R1];
  row_t lv2   [R2];
  row_t lv3   [R3];
  row_t lv4   [CUT_ROWS];
  row_t cut_q [CUT_ROWS];
  row_t lv5   [R5];
  row_t lv6   [R6];
  row_t lv7   [R7];
  row_t lv8   [END_ROWS];

  // stage 1, booth rows
  always_ff @(posedge clk) begin
    if (advance_i) begin
      pp_q <= pp_i;
    end
  end

  csa_level #(.IN_ROWS(PP_ROWS)) u_lvl1 (.rows_i(pp_q), .rows_o(lv1));
  csa_level #(.IN_ROWS(R1))      u_lvl2 (.rows_i(lv1),  .rows_o(lv2));
  csa_level #(.IN_ROWS(R2))      u_lvl3 (.rows_i(lv2),  .rows_o(lv3));
  csa_level #(.IN_ROWS(R3))      u_lvl4 (.rows_i(lv3),  .rows_o(lv4));

  // stage 2, middle cut
  always_ff @(posedge clk) begin
    if (advance_i) begin
      cut_q <= lv4;
    end
  end

  csa_level #(.IN_ROWS(CUT_ROWS)) u_lvl5 (.rows_i(cut_q), .rows_o(lv5));
  csa_level #(.IN_ROWS(R5))       u_lvl6 (.rows_i(lv5),   .rows_o(lv6));
  csa_level #(.IN_ROWS(R6))       u_lvl7 (.rows_i(lv6),   .rows_o(lv7));
  csa_level #(.IN_ROWS(R7))       u_lvl8 (.rows_i(lv7),   .rows_o(lv8));

  // stage 3, last sum and carry
  always_ff @(posedge clk) begin
    if (advance_i) begin
      sum_o   <= lv8[0];
      carry_o <= lv8[1];
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it; exit status is the simulation's

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f tb.f --top-module tb_booth_mul -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0

// ==== tb.f ====
+incdir+verification
hdl/mul_pkg.sv
hdl/booth_r4_encoder.sv
hdl/csa_level.sv
hdl/wallace_tree.sv
hdl/final_adder.sv
hdl/mul_pipe_ctrl.sv
hdl/booth_mul_top.sv
verification/tb_booth_mul.sv

// ==== verification/tb_vectors.svh ====
// vector table for the booth multiplier testbench; include inside a module after importing mul_pkg
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NUM_VEC = 48;
localparam int NUM_DIRECTED = 16;

typedef struct packed {
  operand_t a;
  operand_t b;
  logic     a_signed;
  logic     b_signed;
  row_t     prod;
} vec_t;

vec_t vec_tab [NUM_VEC];

// one LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// exact product with each operand read under its own flag, kept to 128 bits
function automatic row_t ref_product(input operand_t a, input operand_t b,
                                     input logic a_signed, input logic b_signed);
  logic signed [129:0] ea;
  logic signed [129:0] eb;
  logic signed [129:0] p;
  ea = a_signed ? {{66{a[DATA_W-1]}}, a} : {66'b0, a};
  eb = b_signed ? {{66{b[DATA_W-1]}}, b} : {66'b0, b};
  p = ea * eb;
  return p[127:0];
endfunction

function automatic vec_t make_vec(input operand_t a, input operand_t b,
                                  input logic a_signed, input logic b_signed);
  vec_t v;
  v.a = a;
  v.b = b;
  v.a_signed = a_signed;
  v.b_signed = b_signed;
  v.prod = ref_product(a, b, a_signed, b_signed);
  return v;
endfunction

task automatic build_vectors();
  logic [31:0] seed;
  operand_t    ra;
  operand_t    rb;
  seed = 32'h176;
  // directed corners
  vec_tab[0]  = make_vec(64'h0, 64'h0, 1'b0, 1'b0);
  vec_tab[1]  = make_vec(64'h1, 64'h1, 1'b0, 1'b0);
  vec_tab[2]  = make_vec(64'h1, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1, 1'b1);
  vec_tab[3]  = make_vec(64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0, 1'b0);
  vec_tab[4]  = make_vec(64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0, 1'b1);
  vec_tab[5]  = make_vec(64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1, 1'b0);
  vec_tab[6]  = make_vec(64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1, 1'b1);
  vec_tab[7]  = make_vec(64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 1'b1, 1'b1);
  vec_tab[8]  = make_vec(64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1, 1'b1);
  vec_tab[9]  = make_vec(64'hFFFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000, 1'b1, 1'b1);
  vec_tab[10] = make_vec(64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 1'b0, 1'b0);
  vec_tab[11] = make_vec(64'hAAAA_AAAA_AAAA_AAAA, 64'h5555_5555_5555_5555, 1'b0, 1'b0);
  vec_tab[12] = make_vec(64'hAAAA_AAAA_AAAA_AAAA, 64'h5555_5555_5555_5555, 1'b1, 1'b1);
  vec_tab[13] = make_vec(64'h5555_5555_5555_5555, 64'hAAAA_AAAA_AAAA_AAAA, 1'b1, 1'b0);
  vec_tab[14] = make_vec(64'hAAAA_AAAA_AAAA_AAAA, 64'hAAAA_AAAA_AAAA_AAAA, 1'b0, 1'b1);
  vec_tab[15] = make_vec(64'h7FFF_FFFF_FFFF_FFFF, 64'h7FFF_FFFF_FFFF_FFFF, 1'b1, 1'b1);
  // random operands, flags from the top LCG bits
  for (int i = NUM_DIRECTED; i < NUM_VEC; i++) begin
    seed = lcg_next(seed);
    ra[63:32] = seed;
    seed = lcg_next(seed);
    ra[31:0] = seed;
    seed = lcg_next(seed);
    rb[63:32] = seed;
    seed = lcg_next(seed);
    rb[31:0] = seed;
    seed = lcg_next(seed);
    vec_tab[i] = make_vec(ra, rb, seed[31], seed[30]);
  end
endtask

`endif

// ==== verification/tb_booth_mul.sv ====
// testbench for booth_mul_top; runs the vector table once, stops at the first error
`timescale 1ns/10ps

module tb_booth_mul;
  import mul_pkg::*;

  `include "tb_vectors.svh"

  localparam int TIMEOUT_CYCLES = NUM_VEC * 3 + 50;
  // deliveries with out_ready_i held high
  localparam int FREE_RUN = 24;
  // four register stages from acceptance to product
  localparam int LATENCY = 4;

  logic     clk;
  logic     rst;
  logic     in_valid_i;
  logic     a_signed_i;
  logic     b_signed_i;
  operand_t a_i;
  operand_t b_i;
  logic     in_ready_o;
  logic     out_valid_o;
  logic     out_ready_i;
  row_t     product_o;

  int cyc = 0;
  int drv_idx = 0;
  int chk_idx = 0;
  int accept_cyc [NUM_VEC];

  booth_mul_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .in_valid_i (in_valid_i),
    .a_signed_i (a_signed_i),
    .b_signed_i (b_signed_i),
    .a_i        (a_i),
    .b_i        (b_i),
    .in_ready_o (in_ready_o),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .product_o  (product_o)
  );

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      abort_run("timeout, not all products came out in time");
    end
  end

  // driver holds one table entry until it is accepted
  initial begin : drive_inputs
    logic took;
    rst = 1'b1;
    in_valid_i = 1'b0;
    a_signed_i = 1'b0;
    b_signed_i = 1'b0;
    a_i = '0;
    b_i = '0;
    for (int i = 0; i < NUM_VEC; i++) begin
      accept_cyc[i] = 0;
    end
    build_vectors();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    while (drv_idx < NUM_VEC) begin
      a_i = vec_tab[drv_idx].a;
      b_i = vec_tab[drv_idx].b;
      a_signed_i = vec_tab[drv_idx].a_signed;
      b_signed_i = vec_tab[drv_idx].b_signed;
      in_valid_i = 1'b1;
      @(negedge clk);
      took = in_ready_o;
      if (took) begin
        accept_cyc[drv_idx] = cyc;
      end
      @(posedge clk);
      #1;
      if (took) begin
        drv_idx++;
      end
    end
    in_valid_i = 1'b0;
  end

  // back-pressure drops out_ready_i one cycle in three after the free run
  initial begin
    out_ready_i = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      out_ready_i = (chk_idx < FREE_RUN) || (cyc % 3 != 0);
    end
  end

  task automatic check_idle_state();
    assert (out_valid_o == 1'b0)
      else abort_run($sformatf("ERROR out_valid_o in reset expected 0 got %h", out_valid_o));
    assert (in_ready_o == 1'b1)
      else abort_run($sformatf("ERROR in_ready_o in reset expected 1 got %h", in_ready_o));
  endtask

  initial begin : reset_check
    @(negedge clk);
    while (rst) begin
      check_idle_state();
      @(negedge clk);
    end
    check_idle_state();
  end

  // outputs sampled at the falling edge where they are settled
  initial begin : check_outputs
    logic held_valid;
    row_t held;
    held_valid = 1'b0;
    held = '0;
    while (chk_idx < NUM_VEC) begin
      @(negedge clk);
      if (!rst) begin
        if (held_valid) begin
          assert (out_valid_o)
            else abort_run("out_valid_o dropped before the product was taken");
          assert (product_o == held)
            else abort_run($sformatf("ERROR product_o changed in stall, held %h got %h",
                                     held, product_o));
        end
        held_valid = 1'b0;
        if (out_ready_i) begin
          assert (in_ready_o)
            else abort_run($sformatf("ERROR in_ready_o expected 1 got %h", in_ready_o));
        end
        if (out_valid_o && !out_ready_i) begin
          assert (!in_ready_o)
            else abort_run($sformatf("ERROR in_ready_o in stall expected 0 got %h", in_ready_o));
          held_valid = 1'b1;
          held = product_o;
        end
        if (out_valid_o && out_ready_i) begin
          assert (product_o == vec_tab[chk_idx].prod)
            else abort_run($sformatf("ERROR product_o entry %0d expected %h got %h", chk_idx,
                                     vec_tab[chk_idx].prod, product_o));
          // delivery edge comes LATENCY edges after acceptance while nothing stalls
          if (chk_idx < FREE_RUN) begin
            assert (cyc - accept_cyc[chk_idx] == LATENCY)
              else abort_run($sformatf("entry %0d came out %0d cycles after acceptance",
                                       chk_idx, cyc - accept_cyc[chk_idx]));
          end
          chk_idx++;
        end
      end
    end
    $display("TB PASSED");
    $finish;
  end

endmodule
